// ==== hdl/icache_pkg.sv ====
`default_nettype none

package icache_pkg;

	// command on the fetch, prefetch and memory buses
	typedef enum logic [1:0]
	{
		BUS_NONE = 2'h0,
		BUS_LOAD = 2'h1
	} bus_command_t;

	// next-line prefetcher
	typedef enum logic
	{
		PREF_IDLE = 1'b0,
		PREF_RUN  = 1'b1
	} pref_state_t;

	// address split
	localparam int ADDR_W       = 64;
	localparam int BLOCK_W      = 64;
	localparam int BLOCK_OFFSET = 3;
	localparam int INDEX_W      = 5;
	localparam int TAG_W        = ADDR_W - INDEX_W - BLOCK_OFFSET;

	// direct mapped, one block per line
	localparam int NUM_LINES = 1 << INDEX_W;

	// memory response tags, 0 means nothing
	localparam int MEM_TAG_W    = 4;
	localparam int NUM_MEM_TAGS = (1 << MEM_TAG_W) - 1;

	// blocks walked ahead of each new fetch
	localparam int PREF_DEPTH  = 2;
	localparam int PREF_STEP_W = $clog2(PREF_DEPTH + 1);

endpackage

`default_nettype wire

// ==== hdl/icache_mem.sv ====
`timescale 1ns/1ns
`default_nettype none

module icache_mem (
	input  wire                                   clock,
	input  wire                                   rst_n,
	input  wire [icache_pkg::INDEX_W-1:0]         index,
	input  wire [icache_pkg::TAG_W-1:0]           tag,
	input  wire                                   read_enable,
	input  wire [icache_pkg::INDEX_W-1:0]         index_pref,
	input  wire [icache_pkg::TAG_W-1:0]           tag_pref,
	input  wire                                   read_enable_pref,
	input  wire [icache_pkg::MEM_TAG_W-1:0]       issue_tag,
	input  wire [icache_pkg::INDEX_W-1:0]         issue_index,
	input  wire [icache_pkg::TAG_W-1:0]           issue_line_tag,
	input  wire [icache_pkg::MEM_TAG_W-1:0]       fill_tag,
	input  wire [icache_pkg::BLOCK_W-1:0]         fill_data,
	output logic [icache_pkg::BLOCK_W-1:0]        cachemem_data,
	output logic                                  cachemem_valid,
	output logic                                  cachemem_is_miss,
	output logic                                  cachemem_is_miss_pref
);
	// per-line state
	logic [icache_pkg::BLOCK_W-1:0]   data_array     [icache_pkg::NUM_LINES];
	logic [icache_pkg::TAG_W-1:0]     tag_array      [icache_pkg::NUM_LINES];
	logic [icache_pkg::TAG_W-1:0]     pend_tag_array [icache_pkg::NUM_LINES];
	logic [icache_pkg::NUM_LINES-1:0] valid_bits;
	logic [icache_pkg::NUM_LINES-1:0] pend_bits;

	// outstanding requests, indexed by memory tag
	logic [icache_pkg::NUM_MEM_TAGS:1] tbl_live;
	logic [icache_pkg::INDEX_W-1:0]    tbl_index [1:icache_pkg::NUM_MEM_TAGS];
	logic [icache_pkg::TAG_W-1:0]      tbl_tag   [1:icache_pkg::NUM_MEM_TAGS];

	logic                           fill_now;
	logic                           issue_now;
	logic [icache_pkg::INDEX_W-1:0] fill_index;
	logic [icache_pkg::TAG_W-1:0]   fill_line_tag;
	logic                           hit, hit_pref;
	logic                           pend, pend_pref;

	assign fill_now      = fill_tag != '0;
	assign issue_now     = issue_tag != '0;
	assign fill_index    = tbl_index[fill_tag];
	assign fill_line_tag = tbl_tag[fill_tag];

	// pending only counts for the tag that was requested
	assign hit       = valid_bits[index] && tag_array[index] == tag;
	assign pend      = pend_bits[index] && pend_tag_array[index] == tag;
	assign hit_pref  = valid_bits[index_pref] && tag_array[index_pref] == tag_pref;
	assign pend_pref = pend_bits[index_pref] && pend_tag_array[index_pref] == tag_pref;

	assign cachemem_data         = data_array[index];
	assign cachemem_valid        = read_enable && hit;
	assign cachemem_is_miss      = read_enable && !hit && !pend;
	assign cachemem_is_miss_pref = read_enable_pref && !hit_pref && !pend_pref;

	always_ff @(posedge clock)
	begin
		if (!rst_n)
		begin
			valid_bits <= '0;
			pend_bits  <= '0;
			tbl_live   <= '0;
		end
		else
		begin
			if (fill_now)
			begin
				valid_bits[fill_index] <= 1'b1;
				tbl_live[fill_tag]     <= 1'b0;
				// a newer request for another tag keeps the line pending
				if (pend_tag_array[fill_index] == fill_line_tag)
					pend_bits[fill_index] <= 1'b0;
			end
			// issue after fill so a same-edge reuse stays live
			if (issue_now)
			begin
				pend_bits[issue_index] <= 1'b1;
				tbl_live[issue_tag]    <= 1'b1;
			end
		end
	end

	always_ff @(posedge clock)
	begin
		if (fill_now)
		begin
			data_array[fill_index] <= fill_data;
			tag_array[fill_index]  <= fill_line_tag;
		end
		if (issue_now)
		begin
			pend_tag_array[issue_index] <= issue_line_tag;
			tbl_index[issue_tag]        <= issue_index;
			tbl_tag[issue_tag]          <= issue_line_tag;
		end
	end

	// every returned tag was handed out by an earlier accepted request
	fill_tag_live: assert property (@(posedge clock) disable iff (!rst_n)
		fill_now |-> tbl_live[fill_tag]);

	// memory never hands out a tag that is still in flight
	issue_tag_free: assert property (@(posedge clock) disable iff (!rst_n)
		issue_now |-> !tbl_live[issue_tag] || fill_tag == issue_tag);

endmodule

`default_nettype wire

// ==== hdl/icache_controller.sv ====
`timescale 1ns/1ns
`default_nettype none

module icache_controller (
	input  wire                                   clock,
	input  wire                                   rst_n,
	// fetch port
	input  wire [icache_pkg::ADDR_W-1:0]          proc2Icache_addr,
	input  wire icache_pkg::bus_command_t         proc2Icache_command,
	// prefetcher
	input  wire [icache_pkg::ADDR_W-1:0]          pref2Icache_addr,
	input  wire icache_pkg::bus_command_t         pref2Icache_command,
	// memory bus
	input  wire [icache_pkg::MEM_TAG_W-1:0]       Imem2proc_response,
	input  wire [icache_pkg::MEM_TAG_W-1:0]       Imem2proc_tag,
	input  wire [icache_pkg::BLOCK_W-1:0]         Imem2proc_data,
	// cache memory
	input  wire [icache_pkg::BLOCK_W-1:0]         cachemem_data,
	input  wire                                   cachemem_valid,
	input  wire                                   cachemem_is_miss,
	input  wire                                   cachemem_is_miss_pref,
	output icache_pkg::bus_command_t              proc2Imem_command,
	output logic [icache_pkg::ADDR_W-1:0]         proc2Imem_addr,
	output logic [icache_pkg::INDEX_W-1:0]        index,
	output logic [icache_pkg::TAG_W-1:0]          tag,
	output logic                                  read_enable,
	output logic [icache_pkg::INDEX_W-1:0]        index_pref,
	output logic [icache_pkg::TAG_W-1:0]          tag_pref,
	output logic                                  read_enable_pref,
	output logic [icache_pkg::MEM_TAG_W-1:0]      issue_tag,
	output logic [icache_pkg::INDEX_W-1:0]        issue_index,
	output logic [icache_pkg::TAG_W-1:0]          issue_line_tag,
	output logic [icache_pkg::MEM_TAG_W-1:0]      fill_tag,
	output logic [icache_pkg::BLOCK_W-1:0]        fill_data,
	output logic [icache_pkg::BLOCK_W-1:0]        Icache_data_out,
	output logic                                  Icache_data_valid,
	output logic                                  pref_grant
);
	// lookup for both ports
	assign read_enable      = proc2Icache_command == icache_pkg::BUS_LOAD;
	assign read_enable_pref = pref2Icache_command == icache_pkg::BUS_LOAD;
	assign {tag, index} = proc2Icache_addr[icache_pkg::ADDR_W-1:icache_pkg::BLOCK_OFFSET];
	assign {tag_pref, index_pref} =
		pref2Icache_addr[icache_pkg::ADDR_W-1:icache_pkg::BLOCK_OFFSET];

	// returns go straight to the cache
	assign fill_tag  = Imem2proc_tag;
	assign fill_data = Imem2proc_data;

	// processor side
	assign Icache_data_out   = cachemem_data;
	assign Icache_data_valid = read_enable && cachemem_valid;

	// processor miss wins, a refused request just shows up again next cycle
	always_comb
	begin
		proc2Imem_command = icache_pkg::BUS_NONE;
		proc2Imem_addr    = '0;
		issue_tag         = '0;
		issue_index       = '0;
		issue_line_tag    = '0;
		// prefetch line already there or on its way
		pref_grant        = read_enable_pref && !cachemem_is_miss_pref;
		if (cachemem_is_miss)
		begin
			proc2Imem_command = icache_pkg::BUS_LOAD;
			proc2Imem_addr    = {tag, index, {icache_pkg::BLOCK_OFFSET{1'b0}}};
			issue_tag         = Imem2proc_response;
			issue_index       = index;
			issue_line_tag    = tag;
		end
		else if (cachemem_is_miss_pref)
		begin
			proc2Imem_command = icache_pkg::BUS_LOAD;
			proc2Imem_addr    = {tag_pref, index_pref, {icache_pkg::BLOCK_OFFSET{1'b0}}};
			issue_tag         = Imem2proc_response;
			issue_index       = index_pref;
			issue_line_tag    = tag_pref;
			pref_grant        = Imem2proc_response != '0;
		end
	end

	bus_addr_aligned: assert property (@(posedge clock) disable iff (!rst_n)
		proc2Imem_command == icache_pkg::BUS_LOAD |->
			proc2Imem_addr[icache_pkg::BLOCK_OFFSET-1:0] == '0);

endmodule

`default_nettype wire

// ==== hdl/icache_prefetch.sv ====
`timescale 1ns/1ns
`default_nettype none

module icache_prefetch (
	input  wire                                   clock,
	input  wire                                   rst_n,
	input  wire [icache_pkg::ADDR_W-1:0]          proc2Icache_addr,
	input  wire icache_pkg::bus_command_t         proc2Icache_command,
	input  wire                                   pref_grant,
	output logic [icache_pkg::ADDR_W-1:0]         pref2Icache_addr,
	output icache_pkg::bus_command_t              pref2Icache_command
);
	logic [icache_pkg::ADDR_W-icache_pkg::BLOCK_OFFSET-1:0] fetch_block;
	logic [icache_pkg::ADDR_W-icache_pkg::BLOCK_OFFSET-1:0] base_block;
	logic [icache_pkg::ADDR_W-icache_pkg::BLOCK_OFFSET-1:0] next_block;
	logic [icache_pkg::PREF_STEP_W-1:0]                     step;
	icache_pkg::pref_state_t                                state;
	logic                                                   restart;

	assign fetch_block = proc2Icache_addr[icache_pkg::ADDR_W-1:icache_pkg::BLOCK_OFFSET];
	assign restart = proc2Icache_command == icache_pkg::BUS_LOAD && fetch_block != base_block;
	assign next_block =
		base_block + (icache_pkg::ADDR_W - icache_pkg::BLOCK_OFFSET)'(step);

	assign pref2Icache_addr    = {next_block, {icache_pkg::BLOCK_OFFSET{1'b0}}};
	assign pref2Icache_command = (state == icache_pkg::PREF_RUN) ?
		icache_pkg::BUS_LOAD : icache_pkg::BUS_NONE;

	always_ff @(posedge clock)
	begin
		if (!rst_n)
		begin
			state      <= icache_pkg::PREF_IDLE;
			// top block, so the first fetch always starts a walk
			base_block <= '1;
			step       <= '0;
		end
		else if (restart)
		begin
			state      <= icache_pkg::PREF_RUN;
			base_block <= fetch_block;
			step       <= (icache_pkg::PREF_STEP_W)'(1);
		end
		else if (state == icache_pkg::PREF_RUN && pref_grant)
		begin
			// hold the address until granted, stop after the last block
			if (step == (icache_pkg::PREF_STEP_W)'(icache_pkg::PREF_DEPTH))
				state <= icache_pkg::PREF_IDLE;
			else
				step <= step + 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/icache_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module icache_top (
	input  wire                                   clock,
	input  wire                                   rst_n,
	input  wire [icache_pkg::ADDR_W-1:0]          proc2Icache_addr,
	input  wire icache_pkg::bus_command_t         proc2Icache_command,
	input  wire [icache_pkg::MEM_TAG_W-1:0]       Imem2proc_response,
	input  wire [icache_pkg::MEM_TAG_W-1:0]       Imem2proc_tag,
	input  wire [icache_pkg::BLOCK_W-1:0]         Imem2proc_data,
	output icache_pkg::bus_command_t              proc2Imem_command,
	output logic [icache_pkg::ADDR_W-1:0]         proc2Imem_addr,
	output logic [icache_pkg::BLOCK_W-1:0]        Icache_data_out,
	output logic                                  Icache_data_valid
);
	// lookup ports
	logic [icache_pkg::INDEX_W-1:0]   index, index_pref;
	logic [icache_pkg::TAG_W-1:0]     tag, tag_pref;
	logic                             read_enable, read_enable_pref;
	// accepted requests and fills
	logic [icache_pkg::MEM_TAG_W-1:0] issue_tag, fill_tag;
	logic [icache_pkg::INDEX_W-1:0]   issue_index;
	logic [icache_pkg::TAG_W-1:0]     issue_line_tag;
	logic [icache_pkg::BLOCK_W-1:0]   fill_data;
	// cache answers
	logic [icache_pkg::BLOCK_W-1:0]   cachemem_data;
	logic                             cachemem_valid;
	logic                             cachemem_is_miss, cachemem_is_miss_pref;
	// prefetcher
	logic [icache_pkg::ADDR_W-1:0]    pref2Icache_addr;
	icache_pkg::bus_command_t         pref2Icache_command;
	logic                             pref_grant;

	icache_mem icache_mem_i (
		.clock, .rst_n,
		.index, .tag, .read_enable,
		.index_pref, .tag_pref, .read_enable_pref,
		.issue_tag, .issue_index, .issue_line_tag,
		.fill_tag, .fill_data,
		.cachemem_data, .cachemem_valid, .cachemem_is_miss, .cachemem_is_miss_pref
	);

	icache_controller icache_controller_i (
		.clock, .rst_n,
		.proc2Icache_addr, .proc2Icache_command,
		.pref2Icache_addr, .pref2Icache_command,
		.Imem2proc_response, .Imem2proc_tag, .Imem2proc_data,
		.cachemem_data, .cachemem_valid, .cachemem_is_miss, .cachemem_is_miss_pref,
		.proc2Imem_command, .proc2Imem_addr,
		.index, .tag, .read_enable,
		.index_pref, .tag_pref, .read_enable_pref,
		.issue_tag, .issue_index, .issue_line_tag,
		.fill_tag, .fill_data,
		.Icache_data_out, .Icache_data_valid, .pref_grant
	);

	icache_prefetch icache_prefetch_i (
		.clock, .rst_n,
		.proc2Icache_addr, .proc2Icache_command,
		.pref_grant,
		.pref2Icache_addr, .pref2Icache_command
	);

endmodule

`default_nettype wire

// ==== sim/imem_model.sv ====
`timescale 1ns/1ns
`default_nettype none

module imem_model (
	input  wire                                   clock,
	input  wire                                   rst_n,
	input  wire                                   refuse_en,
	input  wire icache_pkg::bus_command_t         proc2Imem_command,
	input  wire [icache_pkg::ADDR_W-1:0]          proc2Imem_addr,
	output logic [icache_pkg::MEM_TAG_W-1:0]      Imem2proc_response,
	output logic [icache_pkg::MEM_TAG_W-1:0]      Imem2proc_tag,
	output logic [icache_pkg::BLOCK_W-1:0]        Imem2proc_data
);
	localparam int LATENCY = 4;
	localparam logic [icache_pkg::BLOCK_W-1:0] DATA_MASK = 64'h5a5a_c3c3_0f0f_9696;

	integer                           seed = 32'hea4c_61c8;
	logic                             refuse_now;
	logic                             accept;
	logic [icache_pkg::MEM_TAG_W-1:0] next_tag;
	logic [icache_pkg::MEM_TAG_W-1:0] pipe_tag  [LATENCY];
	logic [icache_pkg::ADDR_W-1:0]    pipe_addr [LATENCY];

	// answer in the same cycle unless this cycle's draw refuses
	assign Imem2proc_response =
		(proc2Imem_command == icache_pkg::BUS_LOAD && !refuse_now) ? next_tag : '0;
	assign accept = Imem2proc_response != '0;

	// block comes back from the last pipeline stage
	assign Imem2proc_tag  = pipe_tag[LATENCY-1];
	assign Imem2proc_data = pipe_addr[LATENCY-1] ^ DATA_MASK;

	always @(posedge clock)
	begin
		if (!rst_n)
		begin
			refuse_now <= 1'b0;
			next_tag   <= 4'd1;
			for (int i = 0; i < LATENCY; i++)
				pipe_tag[i] <= '0;
		end
		else
		begin
			// one refusal in four while enabled
			refuse_now   <= refuse_en && (($random(seed) & 3) == 0);
			pipe_tag[0]  <= accept ? next_tag : '0;
			pipe_addr[0] <= proc2Imem_addr;
			for (int i = 1; i < LATENCY; i++)
			begin
				pipe_tag[i]  <= pipe_tag[i-1];
				pipe_addr[i] <= pipe_addr[i-1];
			end
			// tags rotate through 1..15, never 0
			if (accept)
				next_tag <= (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
		end
	end

endmodule

`default_nettype wire

// ==== sim/icache_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module icache_tb;
	localparam int NUM_TESTS       = 6;
	localparam int CYCLES_PER_TEST = 400;
	localparam int TIMEOUT_CYCLES  = NUM_TESTS * CYCLES_PER_TEST;
	localparam int FETCH_LIMIT     = 200;
	localparam logic [63:0] DATA_MASK = 64'h5a5a_c3c3_0f0f_9696;
	localparam logic [63:0] ADDR_A    = 64'h0000_0000_0001_0040;
	localparam logic [63:0] ADDR_PREF = 64'h0000_0000_0002_0100;
	// same index as ADDR_A with another tag
	localparam logic [63:0] ADDR_B    = 64'h0000_0001_0001_0040;

	logic                                   clock;
	logic                                   rst_n;
	logic                                   refuse_en;
	logic [icache_pkg::ADDR_W-1:0]          proc2Icache_addr;
	icache_pkg::bus_command_t               proc2Icache_command;
	icache_pkg::bus_command_t               proc2Imem_command;
	logic [icache_pkg::ADDR_W-1:0]          proc2Imem_addr;
	logic [icache_pkg::MEM_TAG_W-1:0]       Imem2proc_response;
	logic [icache_pkg::MEM_TAG_W-1:0]       Imem2proc_tag;
	logic [icache_pkg::BLOCK_W-1:0]         Imem2proc_data;
	logic [icache_pkg::BLOCK_W-1:0]         Icache_data_out;
	logic                                   Icache_data_valid;

	integer      seed = 32'hea4c_61c8;
	string       current_test;
	int          test_errors;
	int          pass_count;
	int          fail_count;
	int          cycle_count;
	int          wait_cycles;
	int          refusals;
	logic [31:0] rand_word;
	logic [63:0] check_expected;

	icache_top icache_top_i (
		.clock, .rst_n,
		.proc2Icache_addr, .proc2Icache_command,
		.Imem2proc_response, .Imem2proc_tag, .Imem2proc_data,
		.proc2Imem_command, .proc2Imem_addr,
		.Icache_data_out, .Icache_data_valid
	);

	imem_model imem_model_i (
		.clock, .rst_n, .refuse_en,
		.proc2Imem_command, .proc2Imem_addr,
		.Imem2proc_response, .Imem2proc_tag, .Imem2proc_data
	);

	// memory content is the block address xor a fixed mask
	function automatic logic [63:0] expected_block(input logic [63:0] addr);
		return {addr[63:3], 3'b000} ^ DATA_MASK;
	endfunction

	initial
	begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	// mid-cycle compare of every valid output and of the memory bus
	always @(negedge clock)
	begin
		if (rst_n)
		begin
			if (Icache_data_valid)
			begin
				check_expected = expected_block(proc2Icache_addr);
				if (Icache_data_out !== check_expected)
				begin
					$display("[ERROR] %s: addr %h expected %h actual %h", current_test,
						proc2Icache_addr, check_expected, Icache_data_out);
					test_errors++;
				end
			end
			// idle bus carries address 0
			if (proc2Imem_command == icache_pkg::BUS_NONE && proc2Imem_addr !== '0)
			begin
				$display("[ERROR] %s: idle bus address expected %h actual %h",
					current_test, 64'h0, proc2Imem_addr);
				test_errors++;
			end
			// loads ask for whole blocks
			if (proc2Imem_command == icache_pkg::BUS_LOAD)
			begin
				if (proc2Imem_addr[2:0] !== 3'b000)
				begin
					$display("[ERROR] %s: bus address expected %h actual %h", current_test,
						{proc2Imem_addr[63:3], 3'b000}, proc2Imem_addr);
					test_errors++;
				end
				if (Imem2proc_response == '0)
					refusals++;
			end
		end
	end

	initial
	begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES)
		begin
			@(posedge clock);
			cycle_count++;
		end
		$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Regression failed");
		$finish;
	end

	task automatic start_test(input string name);
		current_test = name;
		test_errors  = 0;
	endtask

	task automatic end_test();
		@(posedge clock);
		#2;
		proc2Icache_command = icache_pkg::BUS_NONE;
		if (test_errors == 0)
		begin
			$display("test %s: ok", current_test);
			pass_count++;
		end
		else
		begin
			$display("test %s: FAILED with %0d errors", current_test, test_errors);
			fail_count++;
		end
	endtask

	// drive one fetch and hold it until valid rises
	task automatic fetch(input logic [63:0] addr, output int cycles);
		@(posedge clock);
		#2;
		proc2Icache_addr    = addr;
		proc2Icache_command = icache_pkg::BUS_LOAD;
		cycles = 0;
		@(negedge clock);
		while (!Icache_data_valid && cycles < FETCH_LIMIT)
		begin
			@(negedge clock);
			cycles++;
		end
		if (!Icache_data_valid)
		begin
			$display("%s: fetch of %h never returned valid data", current_test, addr);
			test_errors++;
		end
	endtask

	task automatic fetch_expect_hit(input logic [63:0] addr);
		int cycles;
		fetch(addr, cycles);
		if (cycles != 0)
		begin
			$display("%s: fetch of %h waited %0d cycles instead of hitting at once",
				current_test, addr, cycles);
			test_errors++;
		end
	endtask

	initial
	begin
		rst_n               = 1'b0;
		refuse_en           = 1'b0;
		proc2Icache_addr    = '0;
		proc2Icache_command = icache_pkg::BUS_NONE;
		pass_count          = 0;
		fail_count          = 0;
		test_errors         = 0;
		refusals            = 0;
		current_test        = "reset";
		repeat (2) @(posedge clock);
		#2;
		rst_n = 1'b1;

		start_test("cold_miss");
		// bus and fetch port quiet after reset
		@(negedge clock);
		if (proc2Imem_command !== icache_pkg::BUS_NONE)
		begin
			$display("[ERROR] %s: memory command after reset expected %0d actual %0d",
				current_test, icache_pkg::BUS_NONE, proc2Imem_command);
			test_errors++;
		end
		if (Icache_data_valid !== 1'b0)
		begin
			$display("[ERROR] %s: data valid after reset expected %b actual %b",
				current_test, 1'b0, Icache_data_valid);
			test_errors++;
		end
		fetch(ADDR_A, wait_cycles);
		if (wait_cycles == 0)
		begin
			$display("%s: an empty cache answered %h at once", current_test, ADDR_A);
			test_errors++;
		end
		end_test();

		start_test("hit");
		fetch_expect_hit(ADDR_A);
		end_test();

		start_test("prefetch");
		fetch(ADDR_PREF, wait_cycles);
		@(posedge clock);
		#2;
		proc2Icache_command = icache_pkg::BUS_NONE;
		repeat (30) @(posedge clock);
		fetch_expect_hit(ADDR_PREF + 64'd8);
		fetch_expect_hit(ADDR_PREF + 64'd16);
		end_test();

		start_test("conflict");
		fetch(ADDR_B, wait_cycles);
		fetch(ADDR_A, wait_cycles);
		// the line now holds B, so A has to come from memory again
		if (wait_cycles == 0)
		begin
			$display("%s: %h still hit after its line was replaced", current_test, ADDR_A);
			test_errors++;
		end
		end_test();

		start_test("refusal");
		refuse_en = 1'b1;
		refusals  = 0;
		for (int i = 0; i < 8; i++)
			fetch(64'h0000_0000_0030_0000 + 64'(i) * 64'h148, wait_cycles);
		if (refusals == 0)
		begin
			$display("%s: memory refused no request, so no refusal was exercised",
				current_test);
			test_errors++;
		end
		end_test();

		start_test("random_stream");
		for (int i = 0; i < 40; i++)
		begin
			rand_word = $random(seed);
			fetch({rand_word[31:28], 48'h0, rand_word[11:0]}, wait_cycles);
		end
		end_test();

		$display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
		if (fail_count == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== files.f ====
hdl/icache_pkg.sv
hdl/icache_mem.sv
hdl/icache_controller.sv
hdl/icache_prefetch.sv
hdl/icache_top.sv
sim/imem_model.sv
sim/icache_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module icache_tb -f files.f \
	--Mdir obj_dir -o icache_tb_sim
build_status=$?
if [ $build_status -ne 0 ]; then
	echo "verilator build failed with status $build_status"
	exit 1
fi

./obj_dir/icache_tb_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -qx "Regression passed" sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1
